// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module core_tb -Mdir obj_dir -o core_tb_sim
	./obj_dir/core_tb_sim | tee $(LOG)
	@grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: filelist.f
source/core_pkg.sv
source/stage_bus_if.sv
source/alu.sv
source/regfile.sv
source/ifu.sv
source/idu.sv
source/exu.sv
source/lsu.sv
source/rv_core.sv
tests/core_checker.sv
tests/core_tb.sv

// File: source/alu.sv
// alu: add, sub, logic, shifts, set-less-than and branch compares
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire core_pkg::alu_op_e          alu_op,
	input  wire logic [core_pkg::xlen-1:0]  src1,
	input  wire logic [core_pkg::xlen-1:0]  src2,
	output logic      [core_pkg::xlen-1:0]  result
);

	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;

	assign shamt = src2[4:0];
	assign lt_s = $signed(src1) < $signed(src2);
	assign lt_u = src1 < src2;

	always_comb begin
		case (alu_op)
			core_pkg::ALU_ADD:    result = src1 + src2;
			core_pkg::ALU_SUB:    result = src1 - src2;
			core_pkg::ALU_SLL:    result = src1 << shamt;
			core_pkg::ALU_SLT:    result = {31'b0, lt_s};
			core_pkg::ALU_SLTU:   result = {31'b0, lt_u};
			core_pkg::ALU_XOR:    result = src1 ^ src2;
			core_pkg::ALU_SRL:    result = src1 >> shamt;
			core_pkg::ALU_SRA:    result = $unsigned($signed(src1) >>> shamt);
			core_pkg::ALU_OR:     result = src1 | src2;
			core_pkg::ALU_AND:    result = src1 & src2;
			core_pkg::ALU_PASS_B: result = src2;
			// compares for conditional branches
			core_pkg::ALU_EQ:     result = {31'b0, src1 == src2};
			core_pkg::ALU_NE:     result = {31'b0, src1 != src2};
			core_pkg::ALU_LT:     result = {31'b0, lt_s};
			core_pkg::ALU_GE:     result = {31'b0, !lt_s};
			core_pkg::ALU_LTU:    result = {31'b0, lt_u};
			core_pkg::ALU_GEU:    result = {31'b0, !lt_u};
			default:              result = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: source/core_pkg.sv
// shared widths, reset pc, opcode, control and state enums for the rv32i core
`default_nettype none

package core_pkg;

	localparam int xlen = 32;
	localparam int reg_w = 5;
	localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

	// rv32i major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcode_e;

	// compares leave their result in bit 0
	typedef enum logic [4:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B,
		ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
	} alu_op_e;

	typedef enum logic [1:0] {
		JMP_NONE, JMP_JAL, JMP_JALR, JMP_BRANCH
	} jump_e;

	typedef enum logic [3:0] {
		MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU,
		MEM_SB, MEM_SH, MEM_SW
	} mem_e;

	// writeback source, none for branches and stores
	typedef enum logic [1:0] {
		WB_ALU, WB_MEM, WB_LINK, WB_NONE
	} wb_e;

	typedef enum logic [1:0] {
		LSU_IDLE, LSU_SETUP, LSU_ACCESS
	} lsu_state_e;

endpackage

`default_nettype wire

// File: source/exu.sv
// execute unit with alu, branch and jump resolution, next pc and execute register
`timescale 1ns/1ps
`default_nettype none

module exu (
	input  wire logic    clk,
	input  wire logic    arst_n,
	decode_bus_if.sink   decode,
	exec_bus_if.source   exec
);

	logic [core_pkg::xlen-1:0] alu_result;
	logic [core_pkg::xlen-1:0] pc_plus4;
	logic [core_pkg::xlen-1:0] next_pc_d;
	logic                      branch_taken;

	alu i_alu (
		.alu_op (decode.alu_op),
		.src1   (decode.op_a),
		.src2   (decode.op_b),
		.result (alu_result)
	);

	assign pc_plus4 = decode.pc + 32'd4;
	assign branch_taken = (decode.jump == core_pkg::JMP_BRANCH) && alu_result[0];

	always_comb begin
		if (branch_taken)
			next_pc_d = decode.branch_target;
		else if (decode.jump == core_pkg::JMP_JAL)
			next_pc_d = alu_result;
		else if (decode.jump == core_pkg::JMP_JALR)
			// jalr drops bit 0 of the sum
			next_pc_d = {alu_result[core_pkg::xlen-1:1], 1'b0};
		else
			next_pc_d = pc_plus4;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			exec.valid <= 1'b0;
		else if (decode.valid && decode.ready)
			exec.valid <= 1'b1;
		else if (exec.ready)
			exec.valid <= 1'b0;
	end

	// held while the lsu waits on the bus
	always_ff @(posedge clk) begin
		if (decode.valid && decode.ready) begin
			exec.result <= alu_result;
			exec.store_data <= decode.store_src;
			exec.link <= pc_plus4;
			exec.next_pc <= next_pc_d;
			exec.rd <= decode.rd;
			exec.mem <= decode.mem;
			exec.wb <= decode.wb;
		end
	end

	assign decode.ready = !exec.valid || exec.ready;

	// jalr target lands on an even word address
	a_jalr_aligned: assert property (@(posedge clk) disable iff (!arst_n)
		decode.valid && decode.ready && decode.jump == core_pkg::JMP_JALR
		|=> exec.next_pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: source/idu.sv
// decode unit: instruction register, field decode, immediates, operand select
`timescale 1ns/1ps
`default_nettype none

module idu (
	input  wire logic                       clk,
	input  wire logic                       arst_n,
	fetch_bus_if.sink                       fetch,
	decode_bus_if.source                    decode,
	output logic      [core_pkg::reg_w-1:0] rs1_addr,
	output logic      [core_pkg::reg_w-1:0] rs2_addr,
	input  wire logic [core_pkg::xlen-1:0]  rs1_data,
	input  wire logic [core_pkg::xlen-1:0]  rs2_data
);

	logic [core_pkg::xlen-1:0] instr_q;
	logic [core_pkg::xlen-1:0] pc_q;
	logic                      valid_q;
	logic [core_pkg::xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	logic [2:0]                funct3;
	core_pkg::opcode_e         opcode;

	// register-register and register-immediate ops share funct3
	function automatic core_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: alu_sel = alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
			3'b001: alu_sel = core_pkg::ALU_SLL;
			3'b010: alu_sel = core_pkg::ALU_SLT;
			3'b011: alu_sel = core_pkg::ALU_SLTU;
			3'b100: alu_sel = core_pkg::ALU_XOR;
			3'b101: alu_sel = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
			3'b110: alu_sel = core_pkg::ALU_OR;
			default: alu_sel = core_pkg::ALU_AND;
		endcase
	endfunction

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			valid_q <= 1'b0;
		else if (fetch.valid && fetch.ready)
			valid_q <= 1'b1;
		else if (decode.ready)
			valid_q <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (fetch.valid && fetch.ready) begin
			instr_q <= fetch.instr;
			pc_q <= fetch.pc;
		end
	end

	assign fetch.ready = !valid_q || decode.ready;

	assign opcode = core_pkg::opcode_e'(instr_q[6:0]);
	assign funct3 = instr_q[14:12];
	assign rs1_addr = instr_q[19:15];
	assign rs2_addr = instr_q[24:20];

	assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
	assign imm_s = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
	assign imm_b = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30:25],
		instr_q[11:8], 1'b0};
	assign imm_u = {instr_q[31:12], 12'b0};
	assign imm_j = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12], instr_q[20],
		instr_q[30:21], 1'b0};

	always_comb begin
		decode.alu_op = core_pkg::ALU_ADD;
		decode.jump = core_pkg::JMP_NONE;
		decode.mem = core_pkg::MEM_NONE;
		decode.wb = core_pkg::WB_ALU;
		decode.op_a = rs1_data;
		decode.op_b = imm_i;
		case (opcode)
			core_pkg::OPC_LUI: begin
				decode.alu_op = core_pkg::ALU_PASS_B;
				decode.op_b = imm_u;
			end
			core_pkg::OPC_AUIPC: begin
				decode.op_a = pc_q;
				decode.op_b = imm_u;
			end
			core_pkg::OPC_JAL: begin
				decode.op_a = pc_q;
				decode.op_b = imm_j;
				decode.jump = core_pkg::JMP_JAL;
				decode.wb = core_pkg::WB_LINK;
			end
			core_pkg::OPC_JALR: begin
				decode.jump = core_pkg::JMP_JALR;
				decode.wb = core_pkg::WB_LINK;
			end
			core_pkg::OPC_BRANCH: begin
				decode.op_b = rs2_data;
				decode.jump = core_pkg::JMP_BRANCH;
				decode.wb = core_pkg::WB_NONE;
				case (funct3)
					3'b001: decode.alu_op = core_pkg::ALU_NE;
					3'b100: decode.alu_op = core_pkg::ALU_LT;
					3'b101: decode.alu_op = core_pkg::ALU_GE;
					3'b110: decode.alu_op = core_pkg::ALU_LTU;
					3'b111: decode.alu_op = core_pkg::ALU_GEU;
					default: decode.alu_op = core_pkg::ALU_EQ;
				endcase
			end
			core_pkg::OPC_LOAD: begin
				decode.wb = core_pkg::WB_MEM;
				case (funct3)
					3'b000: decode.mem = core_pkg::MEM_LB;
					3'b001: decode.mem = core_pkg::MEM_LH;
					3'b100: decode.mem = core_pkg::MEM_LBU;
					3'b101: decode.mem = core_pkg::MEM_LHU;
					default: decode.mem = core_pkg::MEM_LW;
				endcase
			end
			core_pkg::OPC_STORE: begin
				decode.op_b = imm_s;
				decode.wb = core_pkg::WB_NONE;
				case (funct3)
					3'b000: decode.mem = core_pkg::MEM_SB;
					3'b001: decode.mem = core_pkg::MEM_SH;
					default: decode.mem = core_pkg::MEM_SW;
				endcase
			end
			core_pkg::OPC_OP_IMM:
				decode.alu_op = alu_sel(funct3, instr_q[30] && funct3 == 3'b101);
			core_pkg::OPC_OP: begin
				decode.op_b = rs2_data;
				decode.alu_op = alu_sel(funct3, instr_q[30]);
			end
			// unknown opcode retires as a no-op
			default: decode.wb = core_pkg::WB_NONE;
		endcase
	end

	assign decode.valid = valid_q;
	assign decode.pc = pc_q;
	assign decode.rd = instr_q[11:7];
	assign decode.store_src = rs2_data;
	assign decode.branch_target = pc_q + imm_b;

endmodule

`default_nettype wire

// File: source/ifu.sv
// fetch unit with pc register, single rom read per instruction and fetch token
`timescale 1ns/1ps
`default_nettype none

module ifu (
	input  wire logic                      clk,
	input  wire logic                      arst_n,
	input  wire logic                      redirect_valid,
	input  wire logic [core_pkg::xlen-1:0] next_pc,
	output logic                           imem_req,
	output logic      [core_pkg::xlen-1:0] imem_addr,
	input  wire logic [core_pkg::xlen-1:0] imem_rdata,
	fetch_bus_if.source                    fetch
);

	logic [core_pkg::xlen-1:0] pc;
	logic [core_pkg::xlen-1:0] instr_q;
	logic                      busy;
	// rom data is on the bus this cycle
	logic                      rdata_live;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= core_pkg::reset_pc;
			busy <= 1'b0;
			imem_req <= 1'b0;
			rdata_live <= 1'b0;
			fetch.valid <= 1'b0;
		end else begin
			imem_req <= 1'b0;
			rdata_live <= imem_req;
			if (redirect_valid) begin
				pc <= next_pc;
				busy <= 1'b0;
			end else if (!busy) begin
				imem_req <= 1'b1;
				busy <= 1'b1;
			end
			if (imem_req)
				fetch.valid <= 1'b1;
			else if (fetch.ready)
				fetch.valid <= 1'b0;
		end
	end

	// keep the word in case decode stalls
	always_ff @(posedge clk) begin
		if (rdata_live)
			instr_q <= imem_rdata;
	end

	assign imem_addr = pc;
	assign fetch.pc = pc;
	assign fetch.instr = rdata_live ? imem_rdata : instr_q;

	// a new rom read only once decode has taken the previous word
	a_no_req_with_token: assert property (@(posedge clk) disable iff (!arst_n)
		imem_req |-> !fetch.valid);

endmodule

`default_nettype wire

// File: source/lsu.sv
// load/store unit: apb master, load extension, writeback and retire
`timescale 1ns/1ps
`default_nettype none

module lsu (
	input  wire logic                       clk,
	input  wire logic                       arst_n,
	exec_bus_if.sink                        exec,
	output logic                            psel,
	output logic                            penable,
	output logic                            pwrite,
	output logic      [core_pkg::xlen-1:0]  paddr,
	output logic      [core_pkg::xlen-1:0]  pwdata,
	output logic      [3:0]                 pstrb,
	input  wire logic [core_pkg::xlen-1:0]  prdata,
	input  wire logic                       pready,
	output logic                            wen,
	output logic      [core_pkg::reg_w-1:0] waddr,
	output logic      [core_pkg::xlen-1:0]  wdata,
	output logic                            redirect_valid,
	output logic      [core_pkg::xlen-1:0]  next_pc
);

	core_pkg::lsu_state_e       state;
	core_pkg::mem_e             mem_q;
	core_pkg::wb_e              wb_q;
	logic [core_pkg::xlen-1:0]  result_q;
	logic [core_pkg::xlen-1:0]  store_q;
	logic [core_pkg::xlen-1:0]  link_q;
	logic [core_pkg::xlen-1:0]  next_pc_q;
	logic [core_pkg::reg_w-1:0] rd_q;
	logic                       retire_q;
	logic                       access_done;
	logic [core_pkg::xlen-1:0]  rd_shifted;
	logic [core_pkg::xlen-1:0]  load_data;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= core_pkg::LSU_IDLE;
			retire_q <= 1'b0;
		end else begin
			retire_q <= 1'b0;
			case (state)
				core_pkg::LSU_IDLE:
					if (exec.valid) begin
						if (exec.mem != core_pkg::MEM_NONE)
							state <= core_pkg::LSU_SETUP;
						else
							retire_q <= 1'b1;
					end
				core_pkg::LSU_SETUP:
					state <= core_pkg::LSU_ACCESS;
				default:
					if (pready)
						state <= core_pkg::LSU_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (exec.valid && exec.ready) begin
			result_q <= exec.result;
			store_q <= exec.store_data;
			link_q <= exec.link;
			next_pc_q <= exec.next_pc;
			rd_q <= exec.rd;
			mem_q <= exec.mem;
			wb_q <= exec.wb;
		end
	end

	assign exec.ready = (state == core_pkg::LSU_IDLE);

	// apb signals come straight from the held request
	assign psel = (state != core_pkg::LSU_IDLE);
	assign penable = (state == core_pkg::LSU_ACCESS);
	assign pwrite = mem_q inside {core_pkg::MEM_SB, core_pkg::MEM_SH, core_pkg::MEM_SW};
	assign paddr = {result_q[core_pkg::xlen-1:2], 2'b00};
	assign pwdata = store_q << {result_q[1:0], 3'b000};

	always_comb begin
		case (mem_q)
			core_pkg::MEM_SB: pstrb = 4'b0001 << result_q[1:0];
			core_pkg::MEM_SH: pstrb = 4'b0011 << result_q[1:0];
			core_pkg::MEM_SW: pstrb = 4'b1111;
			default:          pstrb = 4'b0000;
		endcase
	end

	// byte or halfword moved down to bit 0, then extended
	assign rd_shifted = prdata >> {result_q[1:0], 3'b000};

	always_comb begin
		case (mem_q)
			core_pkg::MEM_LB:  load_data = {{24{rd_shifted[7]}}, rd_shifted[7:0]};
			core_pkg::MEM_LBU: load_data = {24'b0, rd_shifted[7:0]};
			core_pkg::MEM_LH:  load_data = {{16{rd_shifted[15]}}, rd_shifted[15:0]};
			core_pkg::MEM_LHU: load_data = {16'b0, rd_shifted[15:0]};
			default:           load_data = prdata;
		endcase
	end

	always_comb begin
		case (wb_q)
			core_pkg::WB_MEM:  wdata = load_data;
			core_pkg::WB_LINK: wdata = link_q;
			default:           wdata = result_q;
		endcase
	end

	assign access_done = (state == core_pkg::LSU_ACCESS) && pready;
	assign redirect_valid = retire_q || access_done;
	assign wen = redirect_valid && (wb_q != core_pkg::WB_NONE);
	assign waddr = rd_q;
	assign next_pc = next_pc_q;

	// access phase always follows a setup phase
	a_penable_after_setup: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(penable) |-> psel && $past(psel) && !$past(penable));

	a_stable_in_wait: assert property (@(posedge clk) disable iff (!arst_n)
		state == core_pkg::LSU_ACCESS && !pready |=> $stable(paddr) && $stable(pwrite));

endmodule

`default_nettype wire

// File: source/regfile.sv
// register file: x1..x31 with two read ports and one write port, x0 reads zero
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input  wire logic                       clk,
	input  wire logic                       arst_n,
	input  wire logic [core_pkg::reg_w-1:0] rs1_addr,
	input  wire logic [core_pkg::reg_w-1:0] rs2_addr,
	output logic      [core_pkg::xlen-1:0]  rs1_data,
	output logic      [core_pkg::xlen-1:0]  rs2_data,
	input  wire logic                       wen,
	input  wire logic [core_pkg::reg_w-1:0] waddr,
	input  wire logic [core_pkg::xlen-1:0]  wdata
);

	logic [core_pkg::xlen-1:0] regs [31:1];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// File: source/rv_core.sv
// top level: fetch, decode, regfile, execute and load/store stages
`timescale 1ns/1ps
`default_nettype none

module rv_core (
	input  wire logic                       clk,
	input  wire logic                       arst_n,
	output logic                            imem_req,
	output logic      [core_pkg::xlen-1:0]  imem_addr,
	input  wire logic [core_pkg::xlen-1:0]  imem_rdata,
	output logic                            psel,
	output logic                            penable,
	output logic                            pwrite,
	output logic      [core_pkg::xlen-1:0]  paddr,
	output logic      [core_pkg::xlen-1:0]  pwdata,
	output logic      [3:0]                 pstrb,
	input  wire logic [core_pkg::xlen-1:0]  prdata,
	input  wire logic                       pready,
	output logic                            commit_wen,
	output logic      [core_pkg::reg_w-1:0] commit_waddr,
	output logic      [core_pkg::xlen-1:0]  commit_wdata
);

	logic                       redirect_valid;
	logic [core_pkg::xlen-1:0]  next_pc;
	logic [core_pkg::reg_w-1:0] rs1_addr, rs2_addr;
	logic [core_pkg::xlen-1:0]  rs1_data, rs2_data;

	fetch_bus_if  fetch_bus ();
	decode_bus_if decode_bus ();
	exec_bus_if   exec_bus ();

	ifu i_ifu (
		.clk(clk), .arst_n(arst_n),
		.redirect_valid(redirect_valid), .next_pc(next_pc),
		.imem_req(imem_req), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
		.fetch(fetch_bus.source)
	);

	idu i_idu (
		.clk(clk), .arst_n(arst_n),
		.fetch(fetch_bus.sink), .decode(decode_bus.source),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data)
	);

	// commit port doubles as the regfile write port
	regfile i_regfile (
		.clk(clk), .arst_n(arst_n),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.wen(commit_wen), .waddr(commit_waddr), .wdata(commit_wdata)
	);

	exu i_exu (
		.clk(clk), .arst_n(arst_n),
		.decode(decode_bus.sink), .exec(exec_bus.source)
	);

	lsu i_lsu (
		.clk(clk), .arst_n(arst_n),
		.exec(exec_bus.sink),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
		.prdata(prdata), .pready(pready),
		.wen(commit_wen), .waddr(commit_waddr), .wdata(commit_wdata),
		.redirect_valid(redirect_valid), .next_pc(next_pc)
	);

endmodule

`default_nettype wire

// File: source/stage_bus_if.sv
// fetch, decode and execute stage-to-stage interfaces with source and sink modports
`timescale 1ns/1ps
`default_nettype none

interface fetch_bus_if;
	logic                      valid;
	logic                      ready;
	logic [core_pkg::xlen-1:0] pc;
	logic [core_pkg::xlen-1:0] instr;

	modport source(output valid, pc, instr, input ready);
	modport sink(input valid, pc, instr, output ready);
endinterface

interface decode_bus_if;
	logic                       valid;
	logic                       ready;
	logic [core_pkg::xlen-1:0]  pc;
	logic [core_pkg::xlen-1:0]  op_a;
	logic [core_pkg::xlen-1:0]  op_b;
	logic [core_pkg::xlen-1:0]  store_src;
	logic [core_pkg::xlen-1:0]  branch_target;
	logic [core_pkg::reg_w-1:0] rd;
	core_pkg::alu_op_e          alu_op;
	core_pkg::jump_e            jump;
	core_pkg::mem_e             mem;
	core_pkg::wb_e              wb;

	modport source(output valid, pc, op_a, op_b, store_src, branch_target, rd,
		alu_op, jump, mem, wb, input ready);
	modport sink(input valid, pc, op_a, op_b, store_src, branch_target, rd,
		alu_op, jump, mem, wb, output ready);
endinterface

interface exec_bus_if;
	logic                       valid;
	logic                       ready;
	logic [core_pkg::xlen-1:0]  result;
	logic [core_pkg::xlen-1:0]  store_data;
	logic [core_pkg::xlen-1:0]  link;
	logic [core_pkg::xlen-1:0]  next_pc;
	logic [core_pkg::reg_w-1:0] rd;
	core_pkg::mem_e             mem;
	core_pkg::wb_e              wb;

	modport source(output valid, result, store_data, link, next_pc, rd, mem, wb,
		input ready);
	modport sink(input valid, result, store_data, link, next_pc, rd, mem, wb,
		output ready);
endinterface

`default_nettype wire

// File: tests/core_checker.sv
// checker for reset state, first fetch, commit and apb write order against the program table
`timescale 1ns/1ps
`default_nettype none

module core_checker #(
	parameter int entries = 36
) (
	input  wire logic        clk,
	input  wire logic        arst_n,
	input  wire logic        imem_req,
	input  wire logic [31:0] imem_addr,
	input  wire logic        psel,
	input  wire logic        penable,
	input  wire logic        pwrite,
	input  wire logic        pready,
	input  wire logic [31:0] paddr,
	input  wire logic [31:0] pwdata,
	input  wire logic [3:0]  pstrb,
	input  wire logic        commit_wen,
	input  wire logic [4:0]  commit_waddr,
	input  wire logic [31:0] commit_wdata,
	input  wire logic [1:0]  kind [entries],
	input  wire logic [31:0] exp_a [entries],
	input  wire logic [31:0] exp_d [entries],
	input  wire logic [3:0]  exp_s [entries],
	output logic             done,
	output logic             timed_out,
	output int               errors
);

	localparam int limit = 400;

	logic        got;
	logic        is_store;
	logic [31:0] ev_a, ev_d;
	logic [3:0]  ev_s;
	int          passed;
	int          cyc;

	// waits for the next commit or apb write transfer sampled before the edge updates
	task automatic next_event();
		int n;
		n = 0;
		got = 1'b0;
		while (!got && n < limit) begin
			@(posedge clk);
			n++;
			if (commit_wen) begin
				got = 1'b1;
				is_store = 1'b0;
				ev_a = {27'b0, commit_waddr};
				ev_d = commit_wdata;
				ev_s = 4'h0;
			end else if (psel && penable && pready && pwrite) begin
				got = 1'b1;
				is_store = 1'b1;
				ev_a = paddr;
				ev_d = pwdata;
				ev_s = pstrb;
			end
		end
	endtask

	initial begin
		done = 1'b0;
		timed_out = 1'b0;
		errors = 0;
		passed = 0;
		cyc = 0;
		@(posedge clk);
		while (!arst_n && cyc < limit) begin
			@(posedge clk);
			cyc++;
		end
		// first edge after release still shows the reset outputs
		if (!arst_n) begin
			$display("timeout: reset was never released");
			timed_out = 1'b1;
		end else if (commit_wen || psel || imem_req) begin
			$display("[ERROR] %0t reset: commit_wen, psel or imem_req not low", $time);
			errors++;
		end
		cyc = 0;
		while (!timed_out && !imem_req && cyc < limit) begin
			@(posedge clk);
			cyc++;
		end
		if (!timed_out && !imem_req) begin
			$display("timeout: the first instruction fetch never happened");
			timed_out = 1'b1;
		end else if (!timed_out && imem_addr != core_pkg::reset_pc) begin
			$display("[ERROR] %0t first fetch at %h, expected %h", $time, imem_addr,
				core_pkg::reset_pc);
			errors++;
		end
		for (int i = 0; i < entries && !timed_out; i++) begin
			if (kind[i] == 2'd1 || kind[i] == 2'd2) begin
				next_event();
				if (!got) begin
					$display("timeout: the commit or store of entry %0d never arrived", i);
					timed_out = 1'b1;
				end else if (is_store != (kind[i] == 2'd2) || ev_a != exp_a[i] ||
					ev_d != exp_d[i] || ev_s != exp_s[i]) begin
					$display("[ERROR] %0t entry %0d: got %s %h %h %h, expected %h %h %h",
						$time, i, is_store ? "store" : "commit", ev_a, ev_d, ev_s,
						exp_a[i], exp_d[i], exp_s[i]);
					errors++;
				end else begin
					$display("entry %0d: ok", i);
					passed++;
				end
			end else begin
				// branches and skipped entries leave no event of their own
				$display("entry %0d: no event expected", i);
				passed++;
			end
		end
		$display("checked %0d entries: %0d passed, %0d errors", entries, passed, errors);
		done = 1'b1;
	end

endmodule

`default_nettype wire

// File: tests/core_tb.sv
// testbench top: clock, reset, rom and apb slave models, program table and run control
`timescale 1ns/1ps
`default_nettype none

module core_tb;

	localparam int entries = 36;
	localparam int run_limit = 20000;
	// entry kinds
	localparam logic [1:0] k_none = 2'd0;
	localparam logic [1:0] k_commit = 2'd1;
	localparam logic [1:0] k_store = 2'd2;
	localparam logic [1:0] k_skip = 2'd3;

	logic        clk;
	logic        arst_n;
	logic        imem_req;
	logic [31:0] imem_addr;
	logic [31:0] imem_rdata;
	logic        psel, penable, pwrite, pready;
	logic [31:0] paddr, pwdata, prdata;
	logic [3:0]  pstrb;
	logic        commit_wen;
	logic [4:0]  commit_waddr;
	logic [31:0] commit_wdata;

	// program table: instruction, kind, rd or address, value or data, strobe
	logic [31:0] prog_instr [entries];
	logic [1:0]  prog_kind [entries];
	logic [31:0] prog_a [entries];
	logic [31:0] prog_d [entries];
	logic [3:0]  prog_s [entries];
	int          n_used;

	logic [31:0] rom [64];
	logic [31:0] dmem [128];
	integer      seed;
	int          wait_cnt;
	logic        done;
	logic        timed_out;
	int          errors;
	int          cyc;

	rv_core i_rv_core (
		.clk(clk), .arst_n(arst_n),
		.imem_req(imem_req), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
		.prdata(prdata), .pready(pready),
		.commit_wen(commit_wen), .commit_waddr(commit_waddr), .commit_wdata(commit_wdata)
	);

	core_checker #(.entries(entries)) i_core_checker (
		.clk(clk), .arst_n(arst_n),
		.imem_req(imem_req), .imem_addr(imem_addr),
		.psel(psel), .penable(penable), .pwrite(pwrite), .pready(pready),
		.paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
		.commit_wen(commit_wen), .commit_waddr(commit_waddr), .commit_wdata(commit_wdata),
		.kind(prog_kind), .exp_a(prog_a), .exp_d(prog_d), .exp_s(prog_s),
		.done(done), .timed_out(timed_out), .errors(errors)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		rtype = {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		itype = {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		stype = {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] btype(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		btype = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] jal_word(input logic [20:0] imm, input logic [4:0] rd);
		jal_word = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
	endfunction

	task automatic add_entry(input logic [31:0] ins, input logic [1:0] k,
		input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
		prog_instr[n_used] = ins;
		prog_kind[n_used] = k;
		prog_a[n_used] = a;
		prog_d[n_used] = d;
		prog_s[n_used] = s;
		n_used++;
	endtask

	initial begin
		n_used = 0;
		add_entry(itype(12'd5, 5'd0, 3'd0, 5'd1, 7'h13), k_commit, 1, 32'd5, 4'h0);
		add_entry(itype(12'hffd, 5'd0, 3'd0, 5'd2, 7'h13), k_commit, 2, 32'hffff_fffd, 4'h0);
		add_entry(rtype(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), k_commit, 3, 32'd2, 4'h0);
		add_entry(rtype(7'h20, 5'd2, 5'd1, 3'd0, 5'd4), k_commit, 4, 32'd8, 4'h0);
		add_entry(rtype(7'h00, 5'd2, 5'd1, 3'd7, 5'd5), k_commit, 5, 32'd5, 4'h0);
		add_entry(rtype(7'h00, 5'd2, 5'd1, 3'd6, 5'd6), k_commit, 6, 32'hffff_fffd, 4'h0);
		add_entry(rtype(7'h00, 5'd2, 5'd1, 3'd4, 5'd7), k_commit, 7, 32'hffff_fff8, 4'h0);
		add_entry(rtype(7'h00, 5'd1, 5'd2, 3'd2, 5'd8), k_commit, 8, 32'd1, 4'h0);
		add_entry(rtype(7'h00, 5'd1, 5'd2, 3'd3, 5'd9), k_commit, 9, 32'd0, 4'h0);
		add_entry(rtype(7'h00, 5'd1, 5'd1, 3'd1, 5'd10), k_commit, 10, 32'h0000_00a0, 4'h0);
		add_entry(rtype(7'h00, 5'd1, 5'd2, 3'd5, 5'd11), k_commit, 11, 32'h07ff_ffff, 4'h0);
		add_entry(rtype(7'h20, 5'd1, 5'd2, 3'd5, 5'd12), k_commit, 12, 32'hffff_ffff, 4'h0);
		add_entry({20'h12345, 5'd13, 7'h37}, k_commit, 13, 32'h1234_5000, 4'h0);
		// x0 write shows on the commit port, then reads back zero
		add_entry(itype(12'd7, 5'd1, 3'd0, 5'd0, 7'h13), k_commit, 0, 32'd12, 4'h0);
		add_entry(rtype(7'h00, 5'd1, 5'd0, 3'd0, 5'd14), k_commit, 14, 32'd5, 4'h0);
		add_entry(btype(13'd8, 5'd1, 5'd1, 3'd0), k_none, 0, 0, 4'h0);
		add_entry(itype(12'd1, 5'd0, 3'd0, 5'd15, 7'h13), k_skip, 0, 0, 4'h0);
		add_entry(btype(13'd8, 5'd1, 5'd1, 3'd1), k_none, 0, 0, 4'h0);
		add_entry(itype(12'd2, 5'd0, 3'd0, 5'd15, 7'h13), k_commit, 15, 32'd2, 4'h0);
		add_entry(jal_word(21'd8, 5'd16), k_commit, 16, 32'd80, 4'h0);
		add_entry(itype(12'd3, 5'd0, 3'd0, 5'd15, 7'h13), k_skip, 0, 0, 4'h0);
		// odd jalr sum 97 lands on 96
		add_entry(itype(12'd97, 5'd0, 3'd0, 5'd17, 7'h13), k_commit, 17, 32'd97, 4'h0);
		add_entry(itype(12'd0, 5'd17, 3'd0, 5'd18, 7'h67), k_commit, 18, 32'd92, 4'h0);
		add_entry(itype(12'd4, 5'd0, 3'd0, 5'd15, 7'h13), k_skip, 0, 0, 4'h0);
		add_entry(itype(12'h100, 5'd0, 3'd0, 5'd20, 7'h13), k_commit, 20, 32'h100, 4'h0);
		add_entry(stype(12'd0, 5'd13, 5'd20, 3'd2), k_store, 32'h100, 32'h1234_5000, 4'hf);
		add_entry(itype(12'hf80, 5'd0, 3'd0, 5'd21, 7'h13), k_commit, 21, 32'hffff_ff80, 4'h0);
		add_entry(stype(12'd5, 5'd21, 5'd20, 3'd0), k_store, 32'h104, 32'hffff_8000, 4'h2);
		add_entry(stype(12'd6, 5'd6, 5'd20, 3'd1), k_store, 32'h104, 32'hfffd_0000, 4'hc);
		add_entry(itype(12'd0, 5'd20, 3'd2, 5'd22, 7'h03), k_commit, 22, 32'h1234_5000, 4'h0);
		add_entry(itype(12'd5, 5'd20, 3'd0, 5'd23, 7'h03), k_commit, 23, 32'hffff_ff80, 4'h0);
		add_entry(itype(12'd5, 5'd20, 3'd4, 5'd24, 7'h03), k_commit, 24, 32'h0000_0080, 4'h0);
		add_entry(itype(12'd6, 5'd20, 3'd1, 5'd25, 7'h03), k_commit, 25, 32'hffff_fffd, 4'h0);
		add_entry(itype(12'd6, 5'd20, 3'd5, 5'd26, 7'h03), k_commit, 26, 32'h0000_fffd, 4'h0);
		add_entry(itype(12'd1, 5'd20, 3'd0, 5'd27, 7'h03), k_commit, 27, 32'h0000_0050, 4'h0);
		// final self loop
		add_entry(jal_word(21'd0, 5'd0), k_commit, 0, 32'd144, 4'h0);

		// unused rom words hold addi x0,x0,0
		for (int i = 0; i < 64; i++)
			rom[i] = (i < n_used) ? prog_instr[i] : 32'h0000_0013;
		for (int i = 0; i < 128; i++)
			dmem[i] = 32'hdead_0000 ^ (i * 32'h0101_0101);
	end

	// rom answers on the cycle after a request
	always @(negedge clk) begin
		if (imem_req)
			imem_rdata <= rom[imem_addr[7:2]];
	end

	// apb slave with 0 to 3 wait states
	always @(negedge clk) begin
		if (arst_n && psel && !penable) begin
			wait_cnt <= $unsigned($random(seed)) % 4;
			pready <= 1'b0;
		end else if (arst_n && psel && penable && !pready) begin
			if (wait_cnt == 0) begin
				pready <= 1'b1;
				if (pwrite) begin
					for (int b = 0; b < 4; b++)
						if (pstrb[b])
							dmem[paddr[8:2]][b*8 +: 8] = pwdata[b*8 +: 8];
				end else begin
					prdata <= dmem[paddr[8:2]];
				end
			end else begin
				wait_cnt <= wait_cnt - 1;
			end
		end else begin
			pready <= 1'b0;
		end
	end

	initial begin
		seed = 32'hed3e83f8;
		clk = 1'b0;
		arst_n = 1'b0;
		imem_rdata = '0;
		prdata = '0;
		pready = 1'b0;
		wait_cnt = 0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		cyc = 0;
		while (!done && cyc < run_limit) begin
			@(posedge clk);
			cyc++;
		end
		if (!done)
			$display("timeout: the checker did not finish the program table");
		if (done && !timed_out && errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
